// ==== src/zet_bus_pkg.sv ====
/*
 * Bus types shared by the master port, the switch and the slaves.
 * Addresses are word addresses (byte address bits 19..1); io space
 * uses the io tag with the same address field.
 */

package zet_bus_pkg;

  // Data, address and lane widths
  typedef logic [15:0] word_t;
  typedef logic [18:0] addr_t;
  typedef logic [1:0]  sel_t;

  // Interrupt lines and interrupt number
  typedef logic [7:0] irq_t;
  typedef logic [2:0] irq_id_t;

  // Master to slave, 41 bits
  typedef struct packed {
    logic  io;   // 1 selects io space
    addr_t adr;
    word_t dat;
    sel_t  sel;
    logic  we;
    logic  cyc;
    logic  stb;
  } bus_req_t;

  // Slave to master, 17 bits
  typedef struct packed {
    word_t dat;
    logic  ack;
  } bus_rsp_t;

endpackage

// ==== src/zet_map_pkg.sv ====
/*
 * System address map and fixed response values.
 * Windows are match/mask pairs over {io tag, word address}; io
 * windows leave address bits 19..16 out of the compare.
 */

package zet_map_pkg;

  // Io tag plus word address
  typedef logic [19:0] tag_adr_t;

  // Rom, mem 0xf0000 - 0xfffff
  localparam tag_adr_t ROM_HI_MATCH  = 20'b0_1111_0000_0000_0000_000;
  localparam tag_adr_t ROM_HI_MASK   = 20'b1_1111_0000_0000_0000_000;

  // Option rom, mem 0xc0000 - 0xcffff
  localparam tag_adr_t ROM_OPT_MATCH = 20'b0_1100_0000_0000_0000_000;
  localparam tag_adr_t ROM_OPT_MASK  = 20'b1_1111_0000_0000_0000_000;

  // Switches and leds, io 0xf100 - 0xf103
  localparam tag_adr_t GPIO_MATCH    = 20'b1_0000_1111_0001_0000_000;
  localparam tag_adr_t GPIO_MASK     = 20'b1_0000_1111_1111_1111_110;

  // Ram takes any memory access left over
  localparam tag_adr_t RAM_MATCH     = 20'b0_0000_0000_0000_0000_000;
  localparam tag_adr_t RAM_MASK      = 20'b1_0000_0000_0000_0000_000;

  // Read value of unmapped io
  localparam zet_bus_pkg::word_t DEFAULT_DATA = 16'hffff;

  // Vector of interrupt 0
  localparam zet_bus_pkg::word_t INT_VECTOR_BASE = 16'd8;

  // Gpio pad widths
  localparam int LED_COUNT = 14;
  localparam int SW_COUNT  = 10;

endpackage

// ==== src/bus_switch.sv ====
/*
 * Combinational address decoder for one master and four targets.
 * Priority is rom, gpio, ram; whatever is left goes to a built-in
 * responder that acks at once with 0xffff. Slave wait states pass
 * straight back to the master.
 */

`timescale 1ns/1ps

module bus_switch (
  input  zet_bus_pkg::bus_req_t req_i,
  output zet_bus_pkg::bus_rsp_t rsp_o,

  output zet_bus_pkg::bus_req_t rom_req_o,
  input  zet_bus_pkg::bus_rsp_t rom_rsp_i,

  output zet_bus_pkg::bus_req_t ram_req_o,
  input  zet_bus_pkg::bus_rsp_t ram_rsp_i,

  output zet_bus_pkg::bus_req_t gpio_req_o,
  input  zet_bus_pkg::bus_rsp_t gpio_rsp_i
);

  zet_map_pkg::tag_adr_t tadr;

  logic hit_rom;
  logic hit_gpio;
  logic hit_ram;
  logic sel_rom;
  logic sel_gpio;
  logic sel_ram;

  function automatic logic win_hit(
    input zet_map_pkg::tag_adr_t a,
    input zet_map_pkg::tag_adr_t match,
    input zet_map_pkg::tag_adr_t mask
  );
    return (a & mask) == match;
  endfunction

  // Same request to every slave with strobes only where selected
  function automatic zet_bus_pkg::bus_req_t route(
    input zet_bus_pkg::bus_req_t r,
    input logic                  en
  );
    zet_bus_pkg::bus_req_t o;
    o     = r;
    o.cyc = r.cyc & en;
    o.stb = r.stb & en;
    return o;
  endfunction

  assign tadr = {req_i.io, req_i.adr};

  assign hit_rom  = win_hit(tadr, zet_map_pkg::ROM_HI_MATCH, zet_map_pkg::ROM_HI_MASK)
                  | win_hit(tadr, zet_map_pkg::ROM_OPT_MATCH, zet_map_pkg::ROM_OPT_MASK);
  assign hit_gpio = win_hit(tadr, zet_map_pkg::GPIO_MATCH, zet_map_pkg::GPIO_MASK);
  assign hit_ram  = win_hit(tadr, zet_map_pkg::RAM_MATCH, zet_map_pkg::RAM_MASK);

  // At most one of these is high
  assign sel_rom  = hit_rom;
  assign sel_gpio = !hit_rom && hit_gpio;
  assign sel_ram  = !hit_rom && !hit_gpio && hit_ram;

  assign rom_req_o  = route(req_i, sel_rom);
  assign ram_req_o  = route(req_i, sel_ram);
  assign gpio_req_o = route(req_i, sel_gpio);

  always_comb begin
    if (sel_rom) begin
      rsp_o = rom_rsp_i;
    end else if (sel_gpio) begin
      rsp_o = gpio_rsp_i;
    end else if (sel_ram) begin
      rsp_o = ram_rsp_i;
    end else begin
      // Default responder acks with zero wait states
      rsp_o.dat = zet_map_pkg::DEFAULT_DATA;
      rsp_o.ack = req_i.cyc & req_i.stb;
    end
  end

endmodule

// ==== src/simple_pic.sv ====
/*
 * Fixed-priority interrupt controller, no programmable registers.
 * Lines are edge sensitive: a line must fall and rise again to be
 * pending a second time. Line 0 has the highest priority.
 */

`timescale 1ns/1ps

module simple_pic (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  zet_bus_pkg::irq_t    intv_i,
  input  logic                 done_i,
  input  zet_bus_pkg::irq_id_t done_id_i,
  output logic                 intr_o,
  output zet_bus_pkg::irq_id_t iid_o
);

  zet_bus_pkg::irq_t intv_q;
  zet_bus_pkg::irq_t pending;
  zet_bus_pkg::irq_t rise;
  zet_bus_pkg::irq_t clr;

  assign rise = intv_i & ~intv_q;
  assign clr  = done_i ? zet_bus_pkg::irq_t'(1) << done_id_i : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      intv_q  <= '0;
      pending <= '0;
    end else begin
      intv_q  <= intv_i;
      // A new edge beats a clear of the same line
      pending <= (pending & ~clr) | rise;
    end
  end

  assign intr_o = |pending;

  // Lowest pending line wins
  always_comb begin
    iid_o = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = zet_bus_pkg::irq_id_t'(i);
      end
    end
  end

endmodule

// ==== src/cpu_port.sv ====
/*
 * CPU side of the bus. Normal cycles go straight to the switch.
 * Interrupt acknowledge cycles (inta high) stay here and are answered
 * one cycle later with vector 8 + id, which also retires that id.
 */

`timescale 1ns/1ps

module cpu_port (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  zet_bus_pkg::bus_req_t master_req_i,
  output zet_bus_pkg::bus_rsp_t master_rsp_o,
  input  logic                  inta_i,
  output logic                  intr_o,

  output zet_bus_pkg::bus_req_t sw_req_o,
  input  zet_bus_pkg::bus_rsp_t sw_rsp_i,

  input  logic                  intr_i,
  input  zet_bus_pkg::irq_id_t  iid_i,
  output logic                  done_o,
  output zet_bus_pkg::irq_id_t  done_id_o
);

  logic                 inta_cyc;
  logic                 ack_q;
  zet_bus_pkg::word_t   vec_q;
  zet_bus_pkg::irq_id_t id_q;

  assign inta_cyc = inta_i & master_req_i.cyc & master_req_i.stb;

  always_comb begin
    sw_req_o     = master_req_i;
    sw_req_o.cyc = master_req_i.cyc & ~inta_i;
    sw_req_o.stb = master_req_i.stb & ~inta_i;
  end

  // One ack per acknowledge cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= inta_cyc & ~ack_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (inta_cyc && !ack_q) begin
      vec_q <= zet_map_pkg::INT_VECTOR_BASE + zet_bus_pkg::word_t'(iid_i);
      id_q  <= iid_i;
    end
  end

  // Switch ack stays low while an acknowledge cycle is held here
  assign master_rsp_o.dat = ack_q ? vec_q : sw_rsp_i.dat;
  assign master_rsp_o.ack = ack_q | sw_rsp_i.ack;

  assign done_o    = ack_q;
  assign done_id_o = id_q;
  assign intr_o    = intr_i;

endmodule

// ==== src/sw_leds.sv ====
/*
 * Switch and LED register slave, one wait state.
 * Reads return the switches zero-extended at any window address;
 * writes go to the LED register by byte lane.
 */

`timescale 1ns/1ps

module sw_leds (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  zet_bus_pkg::bus_req_t            req_i,
  output zet_bus_pkg::bus_rsp_t            rsp_o,
  input  logic [zet_map_pkg::SW_COUNT-1:0] sw_i,
  output logic [zet_map_pkg::LED_COUNT-1:0] leds_o
);

  localparam int LED_TOP = zet_map_pkg::LED_COUNT - 1;

  logic new_req;
  logic ack_q;

  // Accept only while no ack is out
  assign new_req = req_i.cyc & req_i.stb & ~ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q  <= 1'b0;
      leds_o <= '0;
    end else begin
      ack_q <= new_req;
      if (new_req && req_i.we) begin
        if (req_i.sel[0]) leds_o[7:0]       <= req_i.dat[7:0];
        if (req_i.sel[1]) leds_o[LED_TOP:8] <= req_i.dat[LED_TOP:8];
      end
    end
  end

  assign rsp_o.dat = zet_bus_pkg::word_t'(sw_i);
  assign rsp_o.ack = ack_q;

endmodule

// ==== src/kotku_bus.sv ====
/*
 * System bus core: cpu port, address switch, interrupt controller
 * and gpio slave on one clock. Rom and ram sit outside and end their
 * own cycles with ack.
 */

`timescale 1ns/1ps

module kotku_bus (
  input  logic                              clk_i,
  input  logic                              rst_n_i,

  input  zet_bus_pkg::bus_req_t             master_req_i,
  output zet_bus_pkg::bus_rsp_t             master_rsp_o,
  input  logic                              inta_i,
  output logic                              intr_o,
  input  zet_bus_pkg::irq_t                 intv_i,

  output zet_bus_pkg::bus_req_t             rom_req_o,
  input  zet_bus_pkg::bus_rsp_t             rom_rsp_i,
  output zet_bus_pkg::bus_req_t             ram_req_o,
  input  zet_bus_pkg::bus_rsp_t             ram_rsp_i,

  input  logic [zet_map_pkg::SW_COUNT-1:0]  sw_i,
  output logic [zet_map_pkg::LED_COUNT-1:0] leds_o
);

  zet_bus_pkg::bus_req_t sw_req;
  zet_bus_pkg::bus_rsp_t sw_rsp;
  zet_bus_pkg::bus_req_t gpio_req;
  zet_bus_pkg::bus_rsp_t gpio_rsp;

  logic                  intr;
  zet_bus_pkg::irq_id_t  irq_id;
  logic                  done;
  zet_bus_pkg::irq_id_t  done_id;

  cpu_port cpu0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req_i),
    .master_rsp_o (master_rsp_o),
    .inta_i       (inta_i),
    .intr_o       (intr_o),
    .sw_req_o     (sw_req),
    .sw_rsp_i     (sw_rsp),
    .intr_i       (intr),
    .iid_i        (irq_id),
    .done_o       (done),
    .done_id_o    (done_id)
  );

  bus_switch wbs (
    .req_i      (sw_req),
    .rsp_o      (sw_rsp),
    .rom_req_o  (rom_req_o),
    .rom_rsp_i  (rom_rsp_i),
    .ram_req_o  (ram_req_o),
    .ram_rsp_i  (ram_rsp_i),
    .gpio_req_o (gpio_req),
    .gpio_rsp_i (gpio_rsp)
  );

  simple_pic pic0 (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .intv_i    (intv_i),
    .done_i    (done),
    .done_id_i (done_id),
    .intr_o    (intr),
    .iid_o     (irq_id)
  );

  sw_leds gpio0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (gpio_req),
    .rsp_o   (gpio_rsp),
    .sw_i    (sw_i),
    .leds_o  (leds_o)
  );

endmodule

// ==== tb/kotku_ref.svh ====
/*
 * Reference model of the system bus core for the testbench.
 * Port masks use bit 0 for ROM, bit 1 for RAM and bit 2 for GPIO;
 * io ports decode on 16 bits, memory on 20 bits.
 */

`ifndef KOTKU_REF_SVH
`define KOTKU_REF_SVH

// Which slave port must see cyc/stb, zero for the default responder
function automatic logic [2:0] expected_ports(input logic io, input logic [18:0] adr);
  logic [19:0] byte_adr;
  byte_adr = {adr, 1'b0};
  if (io) begin
    if (byte_adr[15:0] >= 16'hf100 && byte_adr[15:0] <= 16'hf103) return 3'b100;
    return 3'b000;
  end
  if (byte_adr[19:16] == 4'hf || byte_adr[19:16] == 4'hc) return 3'b001;
  return 3'b010;
endfunction

// Model memory contents, every address bit folded in
function automatic logic [15:0] model_data(input logic is_rom, input logic [18:0] adr);
  return adr[15:0] ^ {adr[18:16], adr[18:16], 10'h0} ^ (is_rom ? 16'hc3a5 : 16'h1e0f);
endfunction

function automatic logic [15:0] expected_read(input logic io, input logic [18:0] adr,
                                              input logic [9:0] sw);
  case (expected_ports(io, adr))
    3'b001:  return model_data(1'b1, adr);
    3'b010:  return model_data(1'b0, adr);
    3'b100:  return {6'b0, sw};
    default: return 16'hffff;
  endcase
endfunction

// LED register after a write with the given byte lanes
function automatic logic [13:0] led_after_write(input logic [13:0] old,
                                                input logic [15:0] dat, input logic [1:0] sel);
  logic [13:0] leds;
  leds = old;
  if (sel[0]) leds[7:0] = dat[7:0];
  if (sel[1]) leds[13:8] = dat[13:8];
  return leds;
endfunction

function automatic logic [2:0] lowest_pending(input logic [7:0] pend);
  for (int i = 0; i < 8; i++) begin
    if (pend[i]) return i[2:0];
  end
  return 3'd0;
endfunction

// Vector 8 belongs to line 0
function automatic logic [15:0] irq_vector(input logic [7:0] pend);
  return 16'd8 + {13'd0, lowest_pending(pend)};
endfunction

`endif

// ==== tb/tb_kotku_bus.sv ====
/*
 * Testbench for the system bus core. ROM and RAM are modeled here
 * with 0 to 3 wait states. Inputs change on the falling edge and
 * outputs are sampled on the rising edge.
 */

`timescale 1ns/1ps

module tb_kotku_bus;

  `include "kotku_ref.svh"

  // About 300 cycles of at most 6 clocks each, with wide margin
  localparam int MAX_CYCLES = 20000;

  logic                  clk = 1'b0;
  logic                  rst_n;
  zet_bus_pkg::bus_req_t master_req;
  zet_bus_pkg::bus_rsp_t master_rsp;
  logic                  inta;
  logic                  intr;
  zet_bus_pkg::irq_t     intv;
  zet_bus_pkg::bus_req_t rom_req;
  zet_bus_pkg::bus_rsp_t rom_rsp = '0;
  zet_bus_pkg::bus_req_t ram_req;
  zet_bus_pkg::bus_rsp_t ram_rsp = '0;
  logic [9:0]            sw;
  logic [13:0]           leds;

  integer      seed = 32'hcf60a4a3;
  int          cycle_cnt = 0;
  int          chk_count = 0;
  int          err_count = 0;

  // Expectation for the master cycle in flight
  string       test_name = "reset";
  logic [2:0]  exp_ports;
  logic        chk_dat;
  logic [15:0] exp_dat;
  logic [2:0]  seen = '0;
  logic [2:0]  seen_now;
  logic [7:0]  ref_pend;
  logic [13:0] exp_leds;

  logic        slv_rom;
  logic [18:0] slv_adr;
  int          slv_wait;

  kotku_bus dut0 (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .master_req_i (master_req),
    .master_rsp_o (master_rsp),
    .inta_i       (inta),
    .intr_o       (intr),
    .intv_i       (intv),
    .rom_req_o    (rom_req),
    .rom_rsp_i    (rom_rsp),
    .ram_req_o    (ram_req),
    .ram_rsp_i    (ram_rsp),
    .sw_i         (sw),
    .leds_o       (leds)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    err_count++;
    $display("** Error %s: expected %0h, actual %0h", name, exp, act);
  endtask

  // ROM and RAM models, never both busy
  always begin
    @(posedge clk);
    if ((rom_req.cyc && rom_req.stb) || (ram_req.cyc && ram_req.stb)) begin
      slv_rom  = rom_req.cyc;
      slv_adr  = slv_rom ? rom_req.adr : ram_req.adr;
      slv_wait = {$random(seed)} % 4;
      repeat (slv_wait) @(posedge clk);
      @(negedge clk);
      if (slv_rom) rom_rsp = '{model_data(1'b1, slv_adr), 1'b1};
      else ram_rsp = '{model_data(1'b0, slv_adr), 1'b1};
      @(negedge clk);
      rom_rsp = '0;
      ram_rsp = '0;
    end
  end

  // Checks every finished master cycle
  always @(posedge clk) begin
    if (master_req.cyc && master_req.stb) begin
      seen_now = seen | {dut0.gpio_req.cyc & dut0.gpio_req.stb,
                         ram_req.cyc & ram_req.stb, rom_req.cyc & rom_req.stb};
      // Bits 40..2 hold io, adr, dat, sel and we
      if (rom_req.cyc && rom_req[40:2] != master_req[40:2])
        report_mismatch({test_name, " rom path"}, 64'(master_req[40:2]), 64'(rom_req[40:2]));
      if (ram_req.cyc && ram_req[40:2] != master_req[40:2])
        report_mismatch({test_name, " ram path"}, 64'(master_req[40:2]), 64'(ram_req[40:2]));
      if (master_rsp.ack) begin
        chk_count++;
        if (seen_now != exp_ports)
          report_mismatch({test_name, " route"}, 64'(exp_ports), 64'(seen_now));
        if (chk_dat && master_rsp.dat !== exp_dat)
          report_mismatch({test_name, " data"}, 64'(exp_dat), 64'(master_rsp.dat));
        seen_now = '0;
      end
      seen = seen_now;
    end
  end

  task automatic run_cycle(input logic io, input logic [18:0] adr, input logic [15:0] dat,
                           input logic [1:0] sel, input logic we, input logic ack_cycle);
    @(negedge clk);
    master_req = '{io, adr, dat, sel, we, 1'b1, 1'b1};
    inta = ack_cycle;
    @(posedge clk);
    while (!master_rsp.ack) @(posedge clk);
    @(negedge clk);
    master_req = '0;
    inta = 1'b0;
  endtask

  task automatic set_irq_lines(input logic [7:0] lines);
    @(negedge clk);
    ref_pend = ref_pend | (lines & ~intv);
    intv = lines;
  endtask

  task automatic ack_irq();
    exp_dat = irq_vector(ref_pend);
    run_cycle(1'b0, '0, '0, 2'b00, 1'b0, 1'b1);
    ref_pend[lowest_pending(ref_pend)] = 1'b0;
  endtask

  task automatic check_intr(input string name, input logic exp);
    chk_count++;
    if (intr !== exp) report_mismatch(name, 64'(exp), 64'(intr));
  endtask

  initial begin
    logic [31:0] rnd;
    logic        io;
    logic [18:0] adr;
    rst_n = 1'b0;
    master_req = '0;
    inta = 1'b0;
    intv = '0;
    sw = '0;
    chk_dat = 1'b0;
    exp_ports = '0;
    exp_dat = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(posedge clk);
    chk_count++;
    if ({master_rsp.ack, intr, rom_req.cyc, rom_req.stb, ram_req.cyc, ram_req.stb, leds} !== '0)
      report_mismatch("reset", 64'(0), 64'({master_rsp.ack, intr, rom_req.cyc, rom_req.stb,
                                            ram_req.cyc, ram_req.stb, leds}));

    test_name = "random read";
    chk_dat = 1'b1;
    repeat (200) begin
      rnd = $random(seed);
      io  = rnd[31];
      // A quarter of the io reads land in the GPIO window
      if (io) adr = (rnd[1:0] == 2'b00) ? 19'h07880 + 19'(rnd[2]) : {4'h0, rnd[16:2]};
      else adr = rnd[18:0];
      sw = rnd[28:19];
      exp_ports = expected_ports(io, adr);
      exp_dat = expected_read(io, adr, sw);
      run_cycle(io, adr, 16'h0, 2'b11, 1'b0, 1'b0);
    end

    test_name = "mem write";
    chk_dat = 1'b0;
    repeat (60) begin
      rnd = $random(seed);
      adr = 19'($random(seed));
      exp_ports = expected_ports(1'b0, adr);
      run_cycle(1'b0, adr, rnd[15:0], rnd[17:16], 1'b1, 1'b0);
    end

    test_name = "led write";
    exp_leds = '0;
    exp_ports = 3'b100;
    for (int s = 0; s < 4; s++) begin
      repeat (4) begin
        rnd = $random(seed);
        exp_leds = led_after_write(exp_leds, rnd[15:0], s[1:0]);
        run_cycle(1'b1, 19'h07880 + 19'(rnd[16]), rnd[15:0], s[1:0], 1'b1, 1'b0);
        chk_count++;
        if (leds !== exp_leds) report_mismatch(test_name, 64'(exp_leds), 64'(leds));
      end
    end

    test_name = "irq order";
    exp_ports = 3'b000;
    chk_dat = 1'b1;
    ref_pend = '0;
    set_irq_lines(8'b1010_0100);
    repeat (2) @(posedge clk);
    check_intr("irq rise", 1'b1);
    ack_irq();
    set_irq_lines(8'b1010_0101);
    repeat (3) ack_irq();
    // Line 2 is still high but must not be pending again
    @(posedge clk);
    check_intr("irq fall", 1'b0);
    set_irq_lines(8'b1010_0001);
    set_irq_lines(8'b1010_0101);
    repeat (2) @(posedge clk);
    check_intr("irq re-arm", 1'b1);
    ack_irq();
    @(posedge clk);
    check_intr("irq last fall", 1'b0);

    $display("Checks: %0d, errors: %0d", chk_count, err_count);
    if (err_count == 0) $display("ALL CHECKS PASSED");
    else $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+tb
src/zet_bus_pkg.sv
src/zet_map_pkg.sv
src/bus_switch.sv
src/simple_pic.sv
src/cpu_port.sv
src/sw_leds.sv
src/kotku_bus.sv
tb/tb_kotku_bus.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_kotku_bus -f tb.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
